// File: hw/shader_alu.sv
`timescale 1ns/10ps
`include "shader_settings.svh"

module shader_alu
(
	input  logic                       clk,
	input  logic                       rst_n,

	input  shader_back_pkg::dispatch_t in,
	input  logic                       in_valid,
	output logic                       in_ready,

	output shader_back_pkg::wb_t       out,
	output logic                       out_valid,
	input  logic                       out_ready
);

	import shader_back_pkg::*;

	word [`SHADER_LANES-1:0] result;

	// Free slot, or the held result leaves this cycle.
	assign in_ready = ~out_valid | out_ready;

	always_comb
		for (int i = 0; i < `SHADER_LANES; i++)
			case (in.op)
				OP_ADD:  result[i] = in.a[i] + in.b[i];
				OP_SUB:  result[i] = in.a[i] - in.b[i];
				OP_AND:  result[i] = in.a[i] & in.b[i];
				OP_OR:   result[i] = in.a[i] | in.b[i];
				OP_MUL:  result[i] = in.a[i] * in.b[i];
				default: result[i] = in.a[i];
			endcase

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;

	always_ff @(posedge clk)
		if (in_valid & in_ready) begin
			out.group <= in.group;
			out.dest <= in.dest;
			out.lanes <= result;
			out.scalar <= in.scalar;
			out.writeback <= in.writeback;
			out.mask <= in.mask;
			out.mask_update <= in.mask_update;
			out.pc_add <= in.pc_add;
			out.pc_inc <= in.pc_inc;
			out.pc_update <= in.pc_update;
		end

endmodule

// File: hw/shader_back.sv
`timescale 1ns/10ps
`include "shader_settings.svh"

module shader_back
(
	input  logic                          clk,
	input  logic                          rst_n,

	input  shader_back_pkg::dispatch_t    dispatch,
	input  logic                          dispatch_valid,
	output logic                          dispatch_ready,

	input  shader_back_pkg::setup_write_t setup,
	output shader_back_pkg::setup_done_t  setup_done,

	output logic                          loop_valid,
	output shader_back_pkg::group_id      loop_group,

	input  shader_back_pkg::group_id      rd_group,
	input  shader_back_pkg::reg_num       rd_vgpr,
	output shader_back_pkg::word [`SHADER_LANES-1:0] rd_data,
	input  shader_back_pkg::reg_num       rd_sgpr,
	output shader_back_pkg::word          rd_sgpr_data,
	input  shader_back_pkg::group_id      pc_group,
	output shader_back_pkg::word_ptr      pc_value,
	output shader_back_pkg::lane_mask     mask_value
);

	import shader_back_pkg::*;

	wb_t alu_wb, sfu_wb, arb_wb;
	word [`SHADER_LANES-1:0] vgpr_data;
	lane_mask vgpr_mask, mask_data, mask_back;
	group_id vgpr_group, sgpr_group, mask_group, wr_pc_group, pc_back_group;
	reg_num vgpr_num, sgpr_num;
	word sgpr_data;
	word_ptr pc_data, pc_back;

	logic is_sfu, alu_ready, sfu_ready;
	logic alu_valid, alu_wb_ready, sfu_valid, sfu_wb_ready, arb_valid, arb_ready;
	logic vgpr_we, sgpr_we, mask_we, pc_we;

	// Square root goes to the SFU, everything else to the ALU.
	assign is_sfu = dispatch.op == OP_ISQRT;
	assign dispatch_ready = is_sfu ? sfu_ready : alu_ready;

	shader_alu alu
	(
		.clk,
		.rst_n,
		.in(dispatch),
		.in_valid(dispatch_valid & ~is_sfu),
		.in_ready(alu_ready),
		.out(alu_wb),
		.out_valid(alu_valid),
		.out_ready(alu_wb_ready)
	);

	shader_sfu sfu
	(
		.clk,
		.rst_n,
		.in(dispatch),
		.in_valid(dispatch_valid & is_sfu),
		.in_ready(sfu_ready),
		.out(sfu_wb),
		.out_valid(sfu_valid),
		.out_ready(sfu_wb_ready)
	);

	shader_wb_arbiter arbiter
	(
		.clk,
		.rst_n,
		.a(alu_wb),
		.a_valid(alu_valid),
		.a_ready(alu_wb_ready),
		.b(sfu_wb),
		.b_valid(sfu_valid),
		.b_ready(sfu_wb_ready),
		.out(arb_wb),
		.out_valid(arb_valid),
		.out_ready(arb_ready)
	);

	shader_writeback writeback
	(
		.clk,
		.rst_n,
		.wb(arb_wb),
		.wb_valid(arb_valid),
		.wb_ready(arb_ready),
		.setup,
		.setup_done,
		.loop_valid,
		.loop_group,
		.vgpr_we,
		.vgpr_group,
		.vgpr_num,
		.vgpr_data,
		.vgpr_mask,
		.sgpr_we,
		.sgpr_group,
		.sgpr_num,
		.sgpr_data,
		.mask_we,
		.mask_group,
		.mask_data,
		.pc_we,
		.pc_group(wr_pc_group),
		.pc_data,
		.pc_back_group,
		.pc_back,
		.mask_back
	);

	shader_regfile regfile
	(
		.clk,
		.rst_n,
		.vgpr_we,
		.vgpr_group,
		.vgpr_num,
		.vgpr_data,
		.vgpr_mask,
		.sgpr_we,
		.sgpr_group,
		.sgpr_num,
		.sgpr_data,
		.mask_we,
		.mask_group,
		.mask_data,
		.pc_we,
		.pc_group(wr_pc_group),
		.pc_data,
		.pc_back_group,
		.pc_back,
		.mask_back,
		.rd_group,
		.rd_vgpr,
		.rd_data,
		.rd_sgpr,
		.rd_sgpr_data,
		.rd_pc_group(pc_group),
		.rd_pc(pc_value),
		.rd_mask(mask_value)
	);

endmodule

// File: hw/shader_back_pkg.sv
`include "shader_settings.svh"

package shader_back_pkg;

	typedef logic [31:0] word;
	typedef logic [$clog2(`SHADER_GROUPS)-1:0] group_id;
	typedef logic [$clog2(`VGPR_COUNT)-1:0] reg_num;
	typedef logic [`SHADER_LANES-1:0] lane_mask;
	typedef logic signed [7:0] pc_offset;
	typedef logic [15:0] word_ptr;

	typedef enum logic [2:0] {
		OP_ADD   = 3'd0,
		OP_SUB   = 3'd1,
		OP_AND   = 3'd2,
		OP_OR    = 3'd3,
		OP_MUL   = 3'd4,
		OP_MOV   = 3'd5,
		OP_ISQRT = 3'd6
	} shader_op;

	typedef enum logic [1:0] {
		SFU_IDLE = 2'd0,
		SFU_RUN  = 2'd1,
		SFU_DONE = 2'd2
	} sfu_state;

	typedef struct packed {
		shader_op                op;
		group_id                 group;
		reg_num                  dest;
		logic                    scalar;
		logic                    writeback;
		word [`SHADER_LANES-1:0] a;
		word [`SHADER_LANES-1:0] b;
		pc_offset                pc_add;
		logic                    pc_inc;
		logic                    pc_update;
		lane_mask                mask;
		logic                    mask_update;
	} dispatch_t;

	typedef struct packed {
		group_id                 group;
		reg_num                  dest;
		word [`SHADER_LANES-1:0] lanes;
		logic                    scalar;
		logic                    writeback;
		lane_mask                mask;
		logic                    mask_update;
		pc_offset                pc_add;
		logic                    pc_inc;
		logic                    pc_update;
	} wb_t;

	typedef struct packed {
		group_id  group;
		reg_num   gpr;
		word      gpr_value;
		lane_mask mask;
		word_ptr  pc;
		logic     gpr_set;
		logic     mask_set;
		logic     pc_set;
	} setup_write_t;

	typedef struct packed {
		logic gpr;
		logic mask;
		logic submit;
	} setup_done_t;

endpackage

// File: hw/shader_regfile.sv
`timescale 1ns/10ps
`include "shader_settings.svh"

module shader_regfile
(
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic                      vgpr_we,
	input  shader_back_pkg::group_id  vgpr_group,
	input  shader_back_pkg::reg_num   vgpr_num,
	input  shader_back_pkg::word [`SHADER_LANES-1:0] vgpr_data,
	input  shader_back_pkg::lane_mask vgpr_mask,

	input  logic                      sgpr_we,
	input  shader_back_pkg::group_id  sgpr_group,
	input  shader_back_pkg::reg_num   sgpr_num,
	input  shader_back_pkg::word      sgpr_data,

	input  logic                      mask_we,
	input  shader_back_pkg::group_id  mask_group,
	input  shader_back_pkg::lane_mask mask_data,

	input  logic                      pc_we,
	input  shader_back_pkg::group_id  pc_group,
	input  shader_back_pkg::word_ptr  pc_data,

	input  shader_back_pkg::group_id  pc_back_group,
	output shader_back_pkg::word_ptr  pc_back,
	output shader_back_pkg::lane_mask mask_back,

	input  shader_back_pkg::group_id  rd_group,
	input  shader_back_pkg::reg_num   rd_vgpr,
	output shader_back_pkg::word [`SHADER_LANES-1:0] rd_data,
	input  shader_back_pkg::reg_num   rd_sgpr,
	output shader_back_pkg::word      rd_sgpr_data,
	input  shader_back_pkg::group_id  rd_pc_group,
	output shader_back_pkg::word_ptr  rd_pc,
	output shader_back_pkg::lane_mask rd_mask
);

	import shader_back_pkg::*;

	word [`SHADER_LANES-1:0] vgpr [`SHADER_GROUPS][`VGPR_COUNT];
	word sgpr [`SHADER_GROUPS][`SGPR_COUNT];
	lane_mask masks [`SHADER_GROUPS];
	word_ptr pcs [`SHADER_GROUPS];

	assign pc_back = pcs[pc_back_group];
	assign mask_back = masks[pc_back_group];

	assign rd_data = vgpr[rd_group][rd_vgpr];
	assign rd_sgpr_data = sgpr[rd_group][rd_sgpr];
	assign rd_pc = pcs[rd_pc_group];
	assign rd_mask = masks[rd_pc_group];

	always_ff @(posedge clk) begin
		for (int i = 0; i < `SHADER_LANES; i++)
			if (vgpr_we & vgpr_mask[i])
				vgpr[vgpr_group][vgpr_num][i] <= vgpr_data[i];

		if (sgpr_we)
			sgpr[sgpr_group][sgpr_num] <= sgpr_data;
	end

	// All lanes enabled and PC at zero out of reset.
	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n)
			for (int g = 0; g < `SHADER_GROUPS; g++) begin
				masks[g] <= '1;
				pcs[g] <= '0;
			end
		else begin
			if (mask_we)
				masks[mask_group] <= mask_data;
			if (pc_we)
				pcs[pc_group] <= pc_data;
		end

endmodule

// File: hw/shader_settings.svh
`ifndef SHADER_SETTINGS_SVH
`define SHADER_SETTINGS_SVH

// Lanes per wave and thread groups.
`define SHADER_LANES 4
`define SHADER_GROUPS 4

// Registers per group.
`define VGPR_COUNT 8
`define SGPR_COUNT 8

// Writeback delay matching the register file pipeline.
`define REGFILE_STAGES 2

`endif

// File: hw/shader_sfu.sv
`timescale 1ns/10ps
`include "shader_settings.svh"

module shader_sfu
(
	input  logic                       clk,
	input  logic                       rst_n,

	input  shader_back_pkg::dispatch_t in,
	input  logic                       in_valid,
	output logic                       in_ready,

	output shader_back_pkg::wb_t       out,
	output logic                       out_valid,
	input  logic                       out_ready
);

	import shader_back_pkg::*;

	sfu_state state;
	logic [3:0] step;
	wb_t hold;

	logic [`SHADER_LANES-1:0][31:0] rad;
	logic [`SHADER_LANES-1:0][18:0] rem, rem_next, shifted, trial;
	logic [`SHADER_LANES-1:0][15:0] root, root_next;

	assign in_ready = state == SFU_IDLE;
	assign out_valid = state == SFU_DONE;
	assign out = hold;

	// One result bit per step, two radicand bits consumed.
	always_comb
		for (int i = 0; i < `SHADER_LANES; i++) begin
			shifted[i] = {rem[i][16:0], rad[i][31:30]};
			trial[i] = {1'b0, root[i], 2'b01};
			if (shifted[i] >= trial[i]) begin
				rem_next[i] = shifted[i] - trial[i];
				root_next[i] = {root[i][14:0], 1'b1};
			end else begin
				rem_next[i] = shifted[i];
				root_next[i] = {root[i][14:0], 1'b0};
			end
		end

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n) begin
			state <= SFU_IDLE;
			step <= '0;
		end else
			case (state)
				SFU_IDLE:
					if (in_valid) begin
						state <= SFU_RUN;
						step <= '0;
					end
				SFU_RUN: begin
					step <= step + 4'd1;
					if (step == 4'd15)
						state <= SFU_DONE;
				end
				SFU_DONE:
					if (out_ready)
						state <= SFU_IDLE;
				default:
					state <= SFU_IDLE;
			endcase

	always_ff @(posedge clk)
		if (in_valid & in_ready) begin
			hold.group <= in.group;
			hold.dest <= in.dest;
			hold.lanes <= '0;
			hold.scalar <= in.scalar;
			hold.writeback <= in.writeback;
			hold.mask <= in.mask;
			hold.mask_update <= in.mask_update;
			hold.pc_add <= in.pc_add;
			hold.pc_inc <= in.pc_inc;
			hold.pc_update <= in.pc_update;
			rad <= in.a;
			rem <= '0;
			root <= '0;
		end else if (state == SFU_RUN) begin
			for (int i = 0; i < `SHADER_LANES; i++) begin
				rad[i] <= {rad[i][29:0], 2'b00};
				if (step == 4'd15)
					hold.lanes[i] <= {16'd0, root_next[i]};
			end
			rem <= rem_next;
			root <= root_next;
		end

endmodule

// File: hw/shader_wb_arbiter.sv
`timescale 1ns/10ps

module shader_wb_arbiter
(
	input  logic                 clk,
	input  logic                 rst_n,

	input  shader_back_pkg::wb_t a,
	input  logic                 a_valid,
	output logic                 a_ready,

	input  shader_back_pkg::wb_t b,
	input  logic                 b_valid,
	output logic                 b_ready,

	output shader_back_pkg::wb_t out,
	output logic                 out_valid,
	input  logic                 out_ready
);

	logic lock_b, sel_b;

	// Stays on b once offered, until the sink takes it.
	assign sel_b = lock_b | ~a_valid;

	assign out = sel_b ? b : a;
	assign out_valid = sel_b ? b_valid : a_valid;

	assign a_ready = ~sel_b & out_ready;
	assign b_ready = sel_b & out_ready;

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n)
			lock_b <= 1'b0;
		else
			lock_b <= sel_b & b_valid & ~out_ready;

endmodule

// File: hw/shader_writeback.sv
`timescale 1ns/10ps
`include "shader_settings.svh"

module shader_writeback
(
	input  logic                          clk,
	input  logic                          rst_n,

	input  shader_back_pkg::wb_t          wb,
	input  logic                          wb_valid,
	output logic                          wb_ready,

	input  shader_back_pkg::setup_write_t setup,
	output shader_back_pkg::setup_done_t  setup_done,

	output logic                          loop_valid,
	output shader_back_pkg::group_id      loop_group,

	output logic                          vgpr_we,
	output shader_back_pkg::group_id      vgpr_group,
	output shader_back_pkg::reg_num       vgpr_num,
	output shader_back_pkg::word [`SHADER_LANES-1:0] vgpr_data,
	output shader_back_pkg::lane_mask     vgpr_mask,

	output logic                          sgpr_we,
	output shader_back_pkg::group_id      sgpr_group,
	output shader_back_pkg::reg_num       sgpr_num,
	output shader_back_pkg::word          sgpr_data,

	output logic                          mask_we,
	output shader_back_pkg::group_id      mask_group,
	output shader_back_pkg::lane_mask     mask_data,

	output logic                          pc_we,
	output shader_back_pkg::group_id      pc_group,
	output shader_back_pkg::word_ptr      pc_data,

	output shader_back_pkg::group_id      pc_back_group,
	input  shader_back_pkg::word_ptr      pc_back,
	input  shader_back_pkg::lane_mask     mask_back
);

	import shader_back_pkg::*;

	wb_t pipe [`REGFILE_STAGES];
	wb_t pipe_out;
	setup_write_t setup_q;
	word_ptr pc_step;

	logic [`REGFILE_STAGES-1:0] pipe_valid;
	logic out_valid, pipe_pc, pipe_mask, scalar_wb;
	logic setup_gpr, setup_mask, setup_pc;

	assign wb_ready = 1'b1;

	assign pipe_out = pipe[`REGFILE_STAGES - 1];
	assign out_valid = pipe_valid[`REGFILE_STAGES - 1];

	assign pipe_pc = out_valid & (pipe_out.pc_update | pipe_out.pc_inc);
	assign pipe_mask = out_valid & pipe_out.mask_update;
	assign scalar_wb = wb_valid & wb.writeback & wb.scalar;

	assign pc_back_group = pipe_out.group;
	assign pc_step = pipe_out.pc_inc ? 16'd1 : {{8{pipe_out.pc_add[7]}}, pipe_out.pc_add};

	assign loop_valid = pc_we;
	assign loop_group = pc_group;

	// *********************************************************************
	// Register file ports, pipeline ahead of pending setup.
	// *********************************************************************

	always_comb begin
		vgpr_we = out_valid & pipe_out.writeback & ~pipe_out.scalar;
		vgpr_group = pipe_out.group;
		vgpr_num = pipe_out.dest;
		vgpr_data = pipe_out.lanes;
		vgpr_mask = mask_back;

		sgpr_we = scalar_wb | setup_gpr;
		sgpr_group = setup_q.group;
		sgpr_num = setup_q.gpr;
		sgpr_data = setup_q.gpr_value;
		if (scalar_wb) begin
			sgpr_group = wb.group;
			sgpr_num = wb.dest;
			sgpr_data = wb.lanes[0];
		end

		mask_we = pipe_mask | setup_mask;
		mask_group = setup_q.group;
		mask_data = setup_q.mask;
		if (pipe_mask) begin
			mask_group = pipe_out.group;
			mask_data = pipe_out.mask;
		end

		pc_we = pipe_pc | setup_pc;
		pc_group = setup_q.group;
		pc_data = setup_q.pc;
		if (pipe_pc) begin
			pc_group = pipe_out.group;
			pc_data = pc_back + pc_step;
		end
	end

	// *********************************************************************
	// Delay line and setup requests.
	// *********************************************************************

	always_ff @(posedge clk) begin
		pipe[0] <= wb;
		for (int i = 1; i < `REGFILE_STAGES; i++)
			pipe[i] <= pipe[i - 1];

		if (setup.gpr_set | setup.mask_set | setup.pc_set)
			setup_q <= setup;
	end

	always_ff @(posedge clk or negedge rst_n)
		if (~rst_n) begin
			pipe_valid <= '0;
			setup_gpr <= 1'b0;
			setup_mask <= 1'b0;
			setup_pc <= 1'b0;
			setup_done <= '0;
		end else begin
			pipe_valid <= {pipe_valid[`REGFILE_STAGES-2:0], wb_valid & wb_ready};

			// Retry while the pipeline holds the port.
			setup_gpr <= (setup_gpr & scalar_wb) | setup.gpr_set;
			setup_mask <= (setup_mask & pipe_mask) | setup.mask_set;
			setup_pc <= (setup_pc & pipe_pc) | setup.pc_set;

			setup_done.gpr <= setup_gpr & ~scalar_wb;
			setup_done.mask <= setup_mask & ~pipe_mask;
			setup_done.submit <= setup_pc & ~pipe_pc;
		end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the shader back end testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f shader_back.f --top-module shader_back_tb -o shader_back_sim \
	&& ./obj_dir/shader_back_sim \
	|| exit 1

// File: shader_back.f
+incdir+hw
hw/shader_back_pkg.sv
hw/shader_alu.sv
hw/shader_sfu.sv
hw/shader_wb_arbiter.sv
hw/shader_writeback.sv
hw/shader_regfile.sv
hw/shader_back.sv
testbench/tb_clock.sv
testbench/shader_back_tb.sv

// File: testbench/shader_back_tb.sv
`timescale 1ns/10ps
`include "shader_settings.svh"

module shader_back_tb;

	import shader_back_pkg::*;

	logic clk, rst_n;
	dispatch_t dispatch;
	logic dispatch_valid, dispatch_ready;
	setup_write_t setup;
	setup_done_t setup_done;
	logic loop_valid;
	group_id loop_group;
	group_id rd_group, pc_group;
	reg_num rd_vgpr, rd_sgpr;
	word [`SHADER_LANES-1:0] rd_data;
	word rd_sgpr_data;
	word_ptr pc_value;
	lane_mask mask_value;

	logic [31:0] field [18];
	int cycle_count = 0;
	int cycle_limit = 0;
	int loop_count = 0;

	// Groups of the PC writes still to come, in issue order.
	group_id loop_expect [$];

	tb_clock clock_gen
	(
		.clk,
		.rst_n
	);

	shader_back UUT
	(
		.clk,
		.rst_n,
		.dispatch,
		.dispatch_valid,
		.dispatch_ready,
		.setup,
		.setup_done,
		.loop_valid,
		.loop_group,
		.rd_group,
		.rd_vgpr,
		.rd_data,
		.rd_sgpr,
		.rd_sgpr_data,
		.pc_group,
		.pc_value,
		.mask_value
	);

	// **********************************************************************
	// Run limit and loop pulse count.
	// **********************************************************************

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
			stop_run("Cycle limit reached.");
		end
	end

	always @(negedge clk)
		if (rst_n && loop_valid) begin
			loop_count++;
			if (loop_expect.size() == 0)
				stop_run("loop_valid pulsed although no PC write was issued.");
			else
				compare_group(loop_group, loop_expect.pop_front(), "loop_group");
		end

	task automatic stop_run(input string reason);
		$display("** FAIL **");
		$fatal(1, "%s", reason);
	endtask

	// **********************************************************************
	// Compare tasks.
	// **********************************************************************

	task automatic compare_lanes(input word [`SHADER_LANES-1:0] got,
		input word [`SHADER_LANES-1:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
			stop_run("Vector register compare failed.");
		end
	endtask

	task automatic compare_word(input word got, input word exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
			stop_run("Scalar register compare failed.");
		end
	endtask

	task automatic compare_pc(input word_ptr got, input word_ptr exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
			stop_run("PC compare failed.");
		end
	endtask

	task automatic compare_mask(input lane_mask got, input lane_mask exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s read %b, expected %b", $time, what, got, exp);
			stop_run("Mask compare failed.");
		end
	endtask

	task automatic compare_group(input group_id got, input group_id exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s read %0d, expected %0d", $time, what, got, exp);
			stop_run("Loop group compare failed.");
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("Mismatch at %0t ns: %s counted %0d, expected %0d", $time, what, got, exp);
			stop_run("Loop pulse count compare failed.");
		end
	endtask

	// **********************************************************************
	// Trace commands.
	// **********************************************************************

	task automatic read_fields(input int fd, input int count);
		logic [31:0] value;
		int got;
		for (int i = 0; i < count; i++) begin
			got = $fscanf(fd, "%h", value);
			if (got != 1)
				stop_run("A trace line has fewer fields than its command needs.");
			field[i] = value;
		end
	endtask

	// Keeps the driver at 2 ns after a rising edge.
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic send_dispatch;
		dispatch_t op;
		op.op = shader_op'(field[0][2:0]);
		op.group = group_id'(field[1]);
		op.dest = reg_num'(field[2]);
		op.scalar = field[3][0];
		op.writeback = field[4][0];
		op.pc_add = pc_offset'(field[5]);
		op.pc_inc = field[6][0];
		op.pc_update = field[7][0];
		op.mask = lane_mask'(field[8]);
		op.mask_update = field[9][0];
		for (int i = 0; i < `SHADER_LANES; i++) begin
			op.a[i] = field[10 + i];
			op.b[i] = field[14 + i];
		end
		dispatch = op;
		dispatch_valid = 1'b1;
		@(negedge clk);
		while (!dispatch_ready)
			@(negedge clk);
		@(posedge clk);
		#2;
		dispatch_valid = 1'b0;
		if (op.pc_inc | op.pc_update)
			loop_expect.push_back(op.group);
		idle_cycles($urandom % 2);
	endtask

	function automatic logic done_for(input logic [31:0] kind);
		case (kind)
			32'h0: return setup_done.gpr;
			32'h1: return setup_done.mask;
			default: return setup_done.submit;
		endcase
	endfunction

	// Kind 0 is a scalar register, 1 a mask, 2 a PC.
	task automatic apply_setup;
		setup_write_t req;
		req = '0;
		req.group = group_id'(field[1]);
		req.gpr = reg_num'(field[2]);
		case (field[0])
			32'h0: begin
				req.gpr_value = field[3];
				req.gpr_set = 1'b1;
			end
			32'h1: begin
				req.mask = lane_mask'(field[3]);
				req.mask_set = 1'b1;
			end
			default: begin
				req.pc = word_ptr'(field[3]);
				req.pc_set = 1'b1;
				loop_expect.push_back(req.group);
			end
		endcase
		setup = req;
		@(posedge clk);
		#2;
		setup = '0;
		@(negedge clk);
		while (!done_for(field[0]))
			@(negedge clk);
		idle_cycles(1);
	endtask

	task automatic expect_vector;
		word [`SHADER_LANES-1:0] exp;
		rd_group = group_id'(field[0]);
		rd_vgpr = reg_num'(field[1]);
		for (int i = 0; i < `SHADER_LANES; i++)
			exp[i] = field[2 + i];
		@(negedge clk);
		compare_lanes(rd_data, exp, $sformatf("v%0d of group %0d", field[1], field[0]));
		idle_cycles(1);
	endtask

	task automatic expect_scalar;
		rd_group = group_id'(field[0]);
		rd_sgpr = reg_num'(field[1]);
		@(negedge clk);
		compare_word(rd_sgpr_data, field[2], $sformatf("s%0d of group %0d", field[1], field[0]));
		idle_cycles(1);
	endtask

	task automatic expect_pc_mask(input logic is_pc);
		pc_group = group_id'(field[0]);
		@(negedge clk);
		if (is_pc)
			compare_pc(pc_value, word_ptr'(field[1]), $sformatf("PC of group %0d", field[0]));
		else
			compare_mask(mask_value, lane_mask'(field[1]),
				$sformatf("mask of group %0d", field[0]));
		idle_cycles(1);
	endtask

	// **********************************************************************
	// Main sequence.
	// **********************************************************************

	initial begin
		int fd;
		int line_count;
		string cmd;
		string line;

		void'($urandom(25631));
		dispatch = '0;
		dispatch_valid = 1'b0;
		setup = '0;
		rd_group = '0;
		rd_vgpr = '0;
		rd_sgpr = '0;
		pc_group = '0;

		fd = $fopen("testbench/shader_back_trace.txt", "r");
		if (fd == 0)
			stop_run("The trace file testbench/shader_back_trace.txt could not be opened.");
		line_count = 0;
		while ($fgets(line, fd) != 0)
			line_count++;
		$fclose(fd);
		cycle_limit = line_count * 40 + 500;
		fd = $fopen("testbench/shader_back_trace.txt", "r");

		wait (rst_n === 1'b1);
		idle_cycles(1);

		while ($fscanf(fd, "%s", cmd) == 1) begin
			if (cmd == "#") begin
				void'($fgets(line, fd));
			end else if (cmd == "d") begin
				read_fields(fd, 18);
				send_dispatch();
			end else if (cmd == "s") begin
				read_fields(fd, 4);
				apply_setup();
			end else if (cmd == "w") begin
				read_fields(fd, 1);
				idle_cycles(int'(field[0]));
			end else if (cmd == "ev") begin
				read_fields(fd, 6);
				expect_vector();
			end else if (cmd == "es") begin
				read_fields(fd, 3);
				expect_scalar();
			end else if (cmd == "ep") begin
				read_fields(fd, 2);
				expect_pc_mask(1'b1);
			end else if (cmd == "em") begin
				read_fields(fd, 2);
				expect_pc_mask(1'b0);
			end else if (cmd == "el") begin
				read_fields(fd, 1);
				compare_count(loop_count, int'(field[0]), "loop_valid pulses");
			end else begin
				stop_run($sformatf("The trace holds an unknown command %s.", cmd));
			end
		end
		$fclose(fd);

		$display("** PASS **");
		$finish;
	end

endmodule

// File: testbench/shader_back_trace.txt
# d op grp dst sc wb pcadd inc upd msk mupd a0-a3 b0-b3 | s kind grp idx val | w cycles
# ev grp reg l0-l3 | es grp reg val | ep grp pc | em grp mask | el loops (all hex)
d 0 0 0 0 1 0 0 0 f 0 1 2 3 ffffffff 10 20 30 1
d 1 0 1 0 1 0 0 0 f 0 100 5 0 80000000 1 6 1 1
d 2 0 2 0 1 0 0 0 f 0 ff00ff00 f0f0f0f0 ffffffff 12345678 0ff00ff0 0f0f0f0f ffff ffff0000
d 3 0 3 0 1 0 0 0 f 0 ff00ff00 f0f0f0f0 0 12345678 0ff00ff0 0f0f0f0f ffff 0
d 4 0 4 0 1 0 0 0 f 0 3 10000 ffffffff 12345 7 10000 2 100
d 5 0 5 0 1 0 0 0 f 0 deadbeef 1 2 3 0 0 0 0
w 6
ev 0 0 11 22 33 0
ev 0 1 ff ffffffff ffffffff 7fffffff
ev 0 2 0f000f00 0 ffff 12340000
ev 0 3 fff0fff0 ffffffff ffff 12345678
ev 0 4 15 0 fffffffe 1234500
ev 0 5 deadbeef 1 2 3
d 6 1 0 0 1 0 0 0 f 0 0 ffffffff 10 3e8 0 0 0 0
d 6 1 1 0 1 0 0 0 f 0 1 2 63 f4240 0 0 0 0
w 28
ev 1 0 0 ffff 4 1f
ev 1 1 1 1 9 3e8
d 6 2 0 0 1 0 0 0 f 0 90 190 2710 1 0 0 0 0
w c
d 0 2 1 0 1 0 0 0 f 0 1 1 1 1 1 2 3 4
d 1 2 2 0 1 0 0 0 f 0 a a a a 1 2 3 4
d 3 2 3 0 1 0 0 0 f 0 100 200 300 400 1 2 3 4
d 5 2 4 0 1 0 0 0 f 0 aa bb cc dd 0 0 0 0
d 2 2 5 0 1 0 0 0 f 0 f f f f 1 2 4 8
d 4 2 6 0 1 0 0 0 f 0 2 3 4 5 2 3 4 5
d 6 2 7 0 1 0 0 0 f 0 4 9 19 31 0 0 0 0
w 28
ev 2 0 c 14 64 1
ev 2 1 2 3 4 5
ev 2 2 9 8 7 6
ev 2 3 101 202 303 404
ev 2 4 aa bb cc dd
ev 2 5 1 2 4 8
ev 2 6 4 9 10 19
ev 2 7 2 3 5 7
d 5 3 0 0 1 0 0 0 f 0 11111111 22222222 33333333 44444444 0 0 0 0
d 5 3 0 0 0 0 0 0 5 1 0 0 0 0 0 0 0 0
w 6
em 3 5
d 5 3 0 0 1 0 0 0 f 0 aaaaaaaa bbbbbbbb cccccccc dddddddd 0 0 0 0
w 6
ev 3 0 aaaaaaaa 22222222 cccccccc 44444444
s 1 3 0 a
em 3 a
d 5 3 0 0 1 0 0 0 f 0 1 2 3 4 0 0 0 0
w 6
ev 3 0 aaaaaaaa 2 cccccccc 4
em 0 f
d 5 0 7 0 0 0 1 0 f 0 0 0 0 0 0 0 0 0
d 5 0 7 0 0 0 1 0 f 0 0 0 0 0 0 0 0 0
d 5 0 7 0 0 5 0 1 f 0 0 0 0 0 0 0 0 0
d 5 0 7 0 0 fe 0 1 f 0 0 0 0 0 0 0 0 0
d 5 0 7 0 0 0 1 0 f 0 0 0 0 0 0 0 0 0
w 6
ep 0 6
el 5
s 0 1 5 cafef00d
es 1 5 cafef00d
s 2 2 0 1234
ep 2 1234
el 6
d 0 1 3 1 1 0 0 0 f 0 5 0 0 0 7 0 0 0
w 4
es 1 3 c

// File: testbench/tb_clock.sv
`timescale 1ns/10ps

module tb_clock
(
	output logic clk,
	output logic rst_n
);

	// 20 ns period.
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset held low for the first 4 cycles.
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule
